/* verilog/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath geometry.
`define WORD_W    32
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000

// Primary opcodes.
`define OP_JUMP  6'h02
`define OP_JAL   6'h03
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BNE   6'h05
`define OP_XORI  6'h0e
`define OP_RTYPE 6'h00

// R-type function codes.
`define FN_JR  6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_SLT 6'h2a

`endif

/* verilog/isaPkg.sv */
package isaPkg;

    typedef struct packed
    {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    typedef struct packed
    {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    typedef struct packed
    {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFormat;

    // Same 32 bits, read per format.
    typedef union packed
    {
        rFormat      r;
        iFormat      i;
        jFormat      j;
        logic [31:0] raw;
    } instrWord;

    localparam logic [4:0] LINK_REG = 5'd31; // JAL return address.

endpackage

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    // Encodings match the decoder's aluOp values.
    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_XOR = 3'd6,
        ALU_SLT = 3'd7
    } aluOpT;

endpackage

/* verilog/ctrlIf.sv */
`timescale 1ns/1ns

interface ctrlIf;

    logic           regDst;
    logic           jump;
    logic           branch;
    logic           memRead;
    logic           memtoReg;
    ctrlPkg::aluOpT aluOp;
    logic           memWrite;
    logic           aluSrc;
    logic           regWrite;
    logic           jumpReg;
    logic           jalLink;

    modport decoder
    (
        output regDst, jump, branch, memRead, memtoReg, aluOp,
        output memWrite, aluSrc, regWrite, jumpReg, jalLink
    );

    modport datapath
    (
        input regDst, memtoReg, aluOp, aluSrc, regWrite, jalLink
    );

    modport pc (input jump, branch, jumpReg);

endinterface

/* verilog/control.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module control
(
    input  logic [5:0] opp,
    input  logic [5:0] func,
    ctrlIf.decoder     ctrl
);

    always_comb
    begin
        // Everything low means no-op.
        ctrl.regDst   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memtoReg = 1'b0;
        ctrl.aluOp    = ctrlPkg::ALU_ADD;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.jalLink  = 1'b0;

        case (opp)
            `OP_JUMP:
            begin
                ctrl.jump = 1'b1;
            end
            `OP_JAL:
            begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.jalLink  = 1'b1;
            end
            `OP_LW:
            begin
                ctrl.memRead  = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.aluSrc   = 1'b1; // Base plus offset.
                ctrl.regWrite = 1'b1;
            end
            `OP_SW:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            `OP_BNE:
            begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ctrlPkg::ALU_SUB; // Compare by subtraction.
            end
            `OP_XORI:
            begin
                ctrl.aluOp    = ctrlPkg::ALU_XOR;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_RTYPE:
            begin
                case (func)
                    `FN_JR:
                    begin
                        ctrl.regDst  = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    `FN_ADD:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    `FN_SUB:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ctrlPkg::ALU_SUB;
                        ctrl.regWrite = 1'b1;
                    end
                    `FN_SLT:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = ctrlPkg::ALU_SLT;
                        ctrl.regWrite = 1'b1;
                    end
                    default:
                    begin
                        // Unknown function, stays a no-op.
                    end
                endcase
            end
            default:
            begin
                // Unknown opcode, stays a no-op.
            end
        endcase
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu
#(
    parameter int Width = 32
)
(
    input  logic [Width-1:0] a,
    input  logic [Width-1:0] b,
    input  ctrlPkg::aluOpT   op,
    output logic [Width-1:0] result,
    output logic             zero
);

    always_comb
    begin
        case (op)
            ctrlPkg::ALU_ADD:
                result = a + b;
            ctrlPkg::ALU_SUB:
                result = a - b;
            ctrlPkg::ALU_XOR:
                result = a ^ b;
            ctrlPkg::ALU_SLT:
                result = ($signed(a) < $signed(b)) ? Width'(1) : '0; // Signed compare.
            default:
                result = '0;
        endcase
    end

    assign zero = (result == '0); // Used by BNE.

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ns

module regFile
#(
    parameter int Width = 32,
    parameter int Depth = 32
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [$clog2(Depth)-1:0] readAddrA,
    input  logic [$clog2(Depth)-1:0] readAddrB,
    output logic [Width-1:0]         readDataA,
    output logic [Width-1:0]         readDataB,
    input  logic                     writeEnable,
    input  logic [$clog2(Depth)-1:0] writeAddr,
    input  logic [Width-1:0]         writeData
);

    logic [Width-1:0] regs [Depth];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int n = 0; n < Depth; n++)
            begin
                regs[n] <= '0;
            end
        end
        else if (writeEnable && (writeAddr != '0))
        begin
            regs[writeAddr] <= writeData; // r0 never written.
        end
    end

    // Register 0 reads as zero.
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* verilog/pcUnit.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module pcUnit
(
    input  logic                clk,
    input  logic                reset,
    ctrlIf.pc                   ctrl,
    input  isaPkg::instrWord    instr,
    input  logic                aluZero,
    input  logic [`WORD_W-1:0]  rsValue,
    output logic [`WORD_W-1:0]  pc,
    output logic [`WORD_W-1:0]  pcPlus4
);

    logic [`WORD_W-1:0] jumpTarget;
    logic [`WORD_W-1:0] branchTarget;
    logic [`WORD_W-1:0] nextPc;

    assign pcPlus4 = pc + `WORD_W'd4;

    // Region bits from PC+4, word index from the instruction.
    assign jumpTarget = {pcPlus4[`WORD_W-1:28], instr.j.target, 2'b00};

    assign branchTarget = pcPlus4
                        + {{(`WORD_W-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};

    always_comb
    begin
        if (ctrl.jumpReg)
            nextPc = rsValue;
        else if (ctrl.jump)
            nextPc = jumpTarget;
        else if (ctrl.branch && !aluZero)
            nextPc = branchTarget; // BNE taken.
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `RESET_PC;
        else
            pc <= nextPc;
    end

endmodule

/* verilog/datapath.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module datapath
(
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrWord    instr,
    ctrlIf.datapath             ctrl,
    input  logic [`WORD_W-1:0]  pcPlus4,
    input  logic [`WORD_W-1:0]  memReadData,
    output logic [`WORD_W-1:0]  rsValue,
    output logic                aluZero,
    output logic [`WORD_W-1:0]  aluResult,
    output logic [`WORD_W-1:0]  storeData
);

    logic [`WORD_W-1:0] rtValue;
    logic [`WORD_W-1:0] immSigned;
    logic [`WORD_W-1:0] immZero;
    logic [`WORD_W-1:0] aluB;
    logic [4:0]         destReg;
    logic [`WORD_W-1:0] writeBack;

    assign immSigned = {{(`WORD_W-16){instr.i.imm[15]}}, instr.i.imm};
    assign immZero   = {{(`WORD_W-16){1'b0}}, instr.i.imm};

    // Logical immediates are zero extended.
    assign aluB = !ctrl.aluSrc                      ? rtValue :
                  (ctrl.aluOp == ctrlPkg::ALU_XOR)  ? immZero : immSigned;

    assign destReg = ctrl.regDst  ? instr.r.rd :
                     ctrl.jalLink ? isaPkg::LINK_REG : instr.i.rt;

    assign writeBack = ctrl.jalLink  ? pcPlus4 :
                       ctrl.memtoReg ? memReadData : aluResult;

    regFile #(.Width(`WORD_W), .Depth(`REG_COUNT)) u_regFile
    (
        .clk         (clk),
        .reset       (reset),
        .readAddrA   (instr.r.rs),
        .readAddrB   (instr.r.rt),
        .readDataA   (rsValue),
        .readDataB   (rtValue),
        .writeEnable (ctrl.regWrite),
        .writeAddr   (destReg),
        .writeData   (writeBack)
    );

    alu #(.Width(`WORD_W)) u_alu
    (
        .a      (rsValue),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign storeData = rtValue; // SW data is rt.

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mipsCore
(
    input  logic               clk,
    input  logic               reset,
    output logic [`WORD_W-1:0] instrAddr,
    input  logic [`WORD_W-1:0] instr,
    output logic [`WORD_W-1:0] dataAddr,
    output logic [`WORD_W-1:0] dataWriteData,
    output logic               dataWrite,
    output logic               dataRead,
    input  logic [`WORD_W-1:0] dataReadData
);

    isaPkg::instrWord   instrFields;
    logic [`WORD_W-1:0] pcPlus4;
    logic [`WORD_W-1:0] rsValue;
    logic               aluZero;

    assign instrFields = instr;

    ctrlIf ctrlBus ();

    control u_control
    (
        .opp  (instrFields.r.opcode),
        .func (instrFields.r.funct),
        .ctrl (ctrlBus.decoder)
    );

    datapath u_datapath
    (
        .clk         (clk),
        .reset       (reset),
        .instr       (instrFields),
        .ctrl        (ctrlBus.datapath),
        .pcPlus4     (pcPlus4),
        .memReadData (dataReadData),
        .rsValue     (rsValue),
        .aluZero     (aluZero),
        .aluResult   (dataAddr),     // Effective address.
        .storeData   (dataWriteData)
    );

    pcUnit u_pcUnit
    (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrlBus.pc),
        .instr   (instrFields),
        .aluZero (aluZero),
        .rsValue (rsValue),
        .pc      (instrAddr),
        .pcPlus4 (pcPlus4)
    );

    assign dataWrite = ctrlBus.memWrite;
    assign dataRead  = ctrlBus.memRead;

endmodule

/* verif/coreTbProgram.svh */
// Columns: expected PC, instruction word, load, store, data address, store data.
// Rows are in execution order, so a skipped slot has no row.
addRow(32'h00, encodeI(`OP_XORI, 5'd0, 5'd1, 16'd5), 1'b0, 1'b0, 32'h00, 32'h00); // r1 = 5.
addRow(32'h04, encodeI(`OP_XORI, 5'd0, 5'd2, 16'd3), 1'b0, 1'b0, 32'h00, 32'h00); // r2 = 3.
addRow(32'h08, encodeI(`OP_SW, 5'd0, 5'd1, 16'd0), 1'b0, 1'b1, 32'h00, 32'h05);
addRow(32'h0c, encodeI(`OP_SW, 5'd0, 5'd2, 16'd4), 1'b0, 1'b1, 32'h04, 32'h03);
addRow(32'h10, encodeR(5'd1, 5'd2, 5'd3, `FN_ADD), 1'b0, 1'b0, 32'h00, 32'h00); // r3 = 8.
addRow(32'h14, encodeI(`OP_SW, 5'd0, 5'd3, 16'd8), 1'b0, 1'b1, 32'h08, 32'h08);
addRow(32'h18, encodeR(5'd1, 5'd2, 5'd5, `FN_SUB), 1'b0, 1'b0, 32'h00, 32'h00); // r5 = 2.
addRow(32'h1c, encodeI(`OP_SW, 5'd0, 5'd5, 16'd12), 1'b0, 1'b1, 32'h0c, 32'h02);
addRow(32'h20, encodeR(5'd1, 5'd2, 5'd6, `FN_SLT), 1'b0, 1'b0, 32'h00, 32'h00); // 5 < 3 false.
addRow(32'h24, encodeR(5'd2, 5'd1, 5'd7, `FN_SLT), 1'b0, 1'b0, 32'h00, 32'h00); // 3 < 5 true.
addRow(32'h28, encodeI(`OP_SW, 5'd0, 5'd6, 16'd16), 1'b0, 1'b1, 32'h10, 32'h00);
addRow(32'h2c, encodeI(`OP_SW, 5'd0, 5'd7, 16'd20), 1'b0, 1'b1, 32'h14, 32'h01);

// Memory round trip through r4.
addRow(32'h30, encodeI(`OP_SW, 5'd0, 5'd3, 16'd0), 1'b0, 1'b1, 32'h00, 32'h08);
addRow(32'h34, encodeI(`OP_LW, 5'd0, 5'd4, 16'd0), 1'b1, 1'b0, 32'h00, 32'h00);
addRow(32'h38, encodeI(`OP_SW, 5'd0, 5'd4, 16'd4), 1'b0, 1'b1, 32'h04, 32'h08);
addRow(32'h3c, 32'h0000_0000, 1'b0, 1'b0, 32'h00, 32'h00); // No-op.

// Branches. The first one skips 0x44.
addRow(32'h40, encodeI(`OP_BNE, 5'd1, 5'd2, 16'd1), 1'b0, 1'b0, 32'h00, 32'h00);
addRow(32'h48, encodeI(`OP_BNE, 5'd1, 5'd1, 16'd1), 1'b0, 1'b0, 32'h00, 32'h00);

// Jumps, link and return.
addRow(32'h4c, encodeJ(`OP_JUMP, 32'h60), 1'b0, 1'b0, 32'h00, 32'h00);
addRow(32'h60, encodeJ(`OP_JAL, 32'h80), 1'b0, 1'b0, 32'h00, 32'h00);
addRow(32'h80, encodeR(5'd31, 5'd0, 5'd0, `FN_JR), 1'b0, 1'b0, 32'h00, 32'h00);
addRow(32'h64, encodeI(`OP_SW, 5'd0, 5'd31, 16'd24), 1'b0, 1'b1, 32'h18, 32'h64);

// r0 stays zero.
addRow(32'h68, encodeI(`OP_XORI, 5'd0, 5'd0, 16'd7), 1'b0, 1'b0, 32'h00, 32'h00);
addRow(32'h6c, encodeI(`OP_SW, 5'd0, 5'd0, 16'd28), 1'b0, 1'b1, 32'h1c, 32'h00);
addRow(32'h70, 32'h0000_0000, 1'b0, 1'b0, 32'h00, 32'h00);

/* verif/coreTb.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module coreTb;

    localparam int ClkHalf      = 4;
    localparam int ResetCycles  = 5;
    localparam int ResetTimeout = 20;
    localparam int DriveDelay   = 1;
    localparam int SettleDelay  = 4; // Sample mid-cycle.
    localparam int MemWords     = 16;

    typedef struct packed
    {
        logic [31:0] pc;
        logic [31:0] word;
        logic        load;
        logic        store;
        logic [31:0] addr;
        logic [31:0] data;
    } progRow;

    logic               clk;
    logic               reset;
    logic [`WORD_W-1:0] instrAddr;
    logic [`WORD_W-1:0] instr;
    logic [`WORD_W-1:0] dataAddr;
    logic [`WORD_W-1:0] dataWriteData;
    logic               dataWrite;
    logic               dataRead;
    logic [`WORD_W-1:0] dataReadData;

    logic [31:0] dataMem [MemWords];
    progRow      progTable [$];
    int          errors;
    int          checks;

    mipsCore u_dut
    (
        .clk           (clk),
        .reset         (reset),
        .instrAddr     (instrAddr),
        .instr         (instr),
        .dataAddr      (dataAddr),
        .dataWriteData (dataWriteData),
        .dataWrite     (dataWrite),
        .dataRead      (dataRead),
        .dataReadData  (dataReadData)
    );

    always #ClkHalf clk = ~clk;

    // Word addressed data memory.
    assign dataReadData = dataMem[dataAddr[5:2]];

    always @(posedge clk)
    begin
        if (dataWrite)
            dataMem[dataAddr[5:2]] <= dataWriteData;
    end

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Target given as a byte address.
    function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] fillWord(input int index);
        return 32'hc0de_0000 | index;
    endfunction

    task automatic addRow(input logic [31:0] pc, input logic [31:0] word, input logic load,
                          input logic store, input logic [31:0] addr, input logic [31:0] data);
        progRow row;
        row.pc    = pc;
        row.word  = word;
        row.load  = load;
        row.store = store;
        row.addr  = addr;
        row.data  = data;
        progTable.push_back(row);
    endtask

    task automatic loadProgram();
        `include "coreTbProgram.svh"
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay reset = 1'b0;
    end

    initial
    begin
        int          cycles;
        int          n;
        logic [31:0] expMem [MemWords];

        clk    = 1'b0;
        instr  = '0; // No-op while in reset.
        errors = 0;
        checks = 0;
        for (n = 0; n < MemWords; n++)
        begin
            dataMem[n] = fillWord(n);
            expMem[n]  = fillWord(n);
        end
        loadProgram();

        cycles = 0;
        while (reset !== 1'b0 && cycles < ResetTimeout)
        begin
            @(posedge clk or negedge reset);
            cycles++;
        end
        if (reset !== 1'b0)
        begin
            $display("Timeout: reset was not released after %0d clock cycles.", ResetTimeout);
            $display("ERRORS FOUND");
            $finish;
        end

        for (n = 0; n < progTable.size(); n++)
        begin
            checkValue("instrAddr", progTable[n].pc, instrAddr);
            instr = progTable[n].word;
            #SettleDelay;
            checkValue("dataWrite", progTable[n].store, dataWrite);
            checkValue("dataRead", progTable[n].load, dataRead);
            if (progTable[n].store || progTable[n].load)
                checkValue("dataAddr", progTable[n].addr, dataAddr);
            if (progTable[n].store)
            begin
                checkValue("dataWriteData", progTable[n].data, dataWriteData);
                expMem[progTable[n].addr[5:2]] = progTable[n].data;
            end
            @(posedge clk);
            #DriveDelay;
        end

        // Only the stores may have changed memory.
        for (n = 0; n < MemWords; n++)
            checkValue($sformatf("dataMem[%0d]", n), expMem[n], dataMem[n]);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
+incdir+verif
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/ctrlIf.sv
verilog/control.sv
verilog/alu.sv
verilog/regFile.sv
verilog/pcUnit.sv
verilog/datapath.sv
verilog/mipsCore.sv
verif/coreTb.sv

/* Bender.yml */
package:
  name: mipscore

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isaPkg.sv
      - verilog/ctrlPkg.sv
      - verilog/ctrlIf.sv
      - verilog/control.sv
      - verilog/alu.sv
      - verilog/regFile.sv
      - verilog/pcUnit.sv
      - verilog/datapath.sv
      - verilog/mipsCore.sv
  - target: test
    include_dirs:
      - verilog
      - verif
    files:
      - verif/coreTb.sv
